// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove build output and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module tb_usb_interface -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== adc_stream.sv ====
`timescale 1ns/100ps

module adc_stream (
	input  logic           ftdi_clk,
	input  logic           reset,
	input  logic           start_i,
	input  logic           take_i,
	output usb_pkg::strm_t strm_o,
	input  logic           fifo_empty_i,
	input  usb_pkg::byte_t fifo_data_i,
	output logic           fifo_rd_en_o
);
	import usb_pkg::*;

	strm_state_e state;
	byte_t       out_q;    // byte shown to the host
	byte_t       nxt_q;    // prefetched byte behind it
	logic        nxt_valid;
	logic        pend;     // fifo_data_i lands this cycle
	logic        showing;
	logic        take;
	logic        land_out;
	logic        land_nxt;

	assign showing = (state == SS_SYNC) || (state == SS_HOLD);
	assign take    = take_i && showing;

	// at most one read outstanding and only with room behind out_q
	assign fifo_rd_en_o = showing && !fifo_empty_i && !pend && !nxt_valid;

	assign land_out = pend && (take || (state == SS_FETCH));
	assign land_nxt = pend && showing && !take;

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			state     <= SS_IDLE;
			nxt_valid <= 1'b0;
			pend      <= 1'b0;
		end else begin
			pend <= fifo_rd_en_o;
			case (state)
				SS_IDLE: begin
					if (start_i) begin
						state <= SS_SYNC;
					end
				end
				SS_SYNC, SS_HOLD: begin
					if (take) begin
						nxt_valid <= 1'b0;
						if (nxt_valid || pend) begin
							state <= SS_HOLD;
						end else if (fifo_rd_en_o) begin
							state <= SS_FETCH; // out_q empty for a cycle
						end else begin
							state <= SS_DONE;
						end
					end else if (land_nxt) begin
						nxt_valid <= 1'b1;
					end
				end
				SS_FETCH: state <= SS_HOLD; // fetched byte lands in out_q
				SS_DONE: state <= SS_IDLE;
				default: state <= SS_IDLE;
			endcase
		end
	end

	always_ff @(posedge ftdi_clk) begin
		if ((state == SS_IDLE) && start_i) begin
			out_q <= SYNC_BYTE;
		end else if (take && nxt_valid) begin
			out_q <= nxt_q;
		end else if (land_out) begin
			out_q <= fifo_data_i;
		end
		if (land_nxt) begin
			nxt_q <= fifo_data_i;
		end
	end

	assign strm_o = '{valid: showing, done: (state == SS_DONE), data: out_q};

endmodule

// ==== compile.f ====
usb_pkg.sv
host_port_fsm.sv
reg_bank.sv
adc_stream.sv
usb_interface.sv
tb_clock_gen.sv
usb_interface_properties.sv
tb_usb_interface.sv

// ==== host_port_fsm.sv ====
`timescale 1ns/100ps

module host_port_fsm (
	input  logic              ftdi_clk,
	input  logic              reset,
	input  usb_pkg::host_rx_t rx_i,
	output usb_pkg::host_tx_t tx_o,
	output usb_pkg::wb_req_t  wb_req_o,
	input  usb_pkg::wb_rsp_t  wb_rsp_i,
	output logic              strm_start_o,
	output logic              strm_take_o,
	input  usb_pkg::strm_t    strm_i
);
	import usb_pkg::*;

	host_state_e state;
	wb_req_t     wb_q;
	logic        rd_q;
	byte_t       dout_q;
	cmd_op_e     op;
	reg_addr_e   addr;
	logic        send_ok;

	function automatic cmd_op_e decode_op(input byte_t b);
		if (!b[7]) begin
			return CMD_NONE;
		end
		return b[6] ? CMD_WRITE : CMD_READ;
	endfunction

	// din is only meaningful in HS_ADDR
	assign op   = decode_op(rx_i.din);
	assign addr = reg_addr_e'(rx_i.din[5:0]);

	// a byte goes out only while the chip has room
	assign send_ok = rx_i.txe &&
		((state == HS_RD_SEND) || ((state == HS_STREAM) && strm_i.valid));

	assign strm_start_o = (state == HS_ADDR) && (op == CMD_READ) && (addr == ADCDATA);
	assign strm_take_o  = (state == HS_STREAM) && send_ok;

	always_comb begin
		tx_o.rd    = rd_q;
		tx_o.wr    = send_ok;
		tx_o.isout = (state == HS_RD_SEND) || (state == HS_STREAM);
		tx_o.dout  = (state == HS_STREAM) ? strm_i.data : dout_q;
	end

	assign wb_req_o = wb_q;

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			state <= HS_IDLE;
			rd_q  <= 1'b0;
			wb_q  <= '0;
		end else begin
			rd_q <= 1'b0; // one cycle strobe
			case (state)
				HS_IDLE: begin
					if (rx_i.rxf) begin
						rd_q  <= 1'b1;
						state <= HS_ADDR;
					end
				end
				HS_ADDR: begin
					wb_q.adr <= addr;
					case (op)
						CMD_WRITE: state <= HS_WR_WAIT;
						CMD_READ: begin
							if (addr == ADCDATA) begin
								state <= HS_STREAM; // dump bypasses the bus
							end else begin
								wb_q.cyc <= 1'b1;
								wb_q.stb <= 1'b1;
								wb_q.we  <= 1'b0;
								state    <= HS_RD_REG;
							end
						end
						default: state <= HS_IDLE; // bit 7 clear
					endcase
				end
				HS_WR_WAIT: begin
					if (rx_i.rxf) begin
						rd_q  <= 1'b1;
						state <= HS_WR_DATA;
					end
				end
				HS_WR_DATA: begin
					if (!wb_q.stb) begin
						wb_q.cyc <= 1'b1;
						wb_q.stb <= 1'b1;
						wb_q.we  <= 1'b1;
						wb_q.dat <= rx_i.din;
					end else if (wb_rsp_i.ack || wb_rsp_i.err) begin
						wb_q.cyc <= 1'b0;
						wb_q.stb <= 1'b0;
						wb_q.we  <= 1'b0;
						state    <= HS_IDLE;
					end
				end
				HS_RD_REG: begin
					if (wb_rsp_i.ack || wb_rsp_i.err) begin
						wb_q.cyc <= 1'b0;
						wb_q.stb <= 1'b0;
						state    <= wb_rsp_i.err ? HS_IDLE : HS_RD_SEND; // nothing sent on err
					end
				end
				HS_RD_SEND: begin
					if (rx_i.txe) begin
						state <= HS_IDLE;
					end
				end
				HS_STREAM: begin
					if (strm_i.done) begin
						state <= HS_IDLE;
					end
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	// read data waits here until txe
	always_ff @(posedge ftdi_clk) begin
		if ((state == HS_RD_REG) && wb_rsp_i.ack) begin
			dout_q <= wb_rsp_i.dat;
		end
	end

endmodule

// ==== reg_bank.sv ====
`timescale 1ns/100ps

module reg_bank (
	input  logic                ftdi_clk,
	input  logic                reset_i,
	input  usb_pkg::wb_req_t    wb_req_i,
	output usb_pkg::wb_rsp_t    wb_rsp_o,
	input  usb_pkg::byte_t      status_i,
	input  usb_pkg::word_t      extclk_frequency_i,
	input  usb_pkg::word_t      maxsamples_i,
	input  usb_pkg::phase_t     phase_i,
	input  logic                phase_done_i,
	output usb_pkg::byte_t      gain_o,
	output usb_pkg::settings_t  settings_o,
	output usb_pkg::trig_ctrl_t trig_o,
	output usb_pkg::word_t      maxsamples_o,
	output usb_pkg::phase_t     phase_o,
	output logic                phase_ld_o,
	output logic                reset_o
);
	import usb_pkg::*;

	logic   rst;
	logic   soft_rst_q;
	logic   ack_q;
	logic   err_q;
	byte_t  dat_q;
	byte_t  echo_q;
	word_t  samples_q;
	word_t  offset_q;
	word_t  freq_q;
	logic   freq_lock;
	logic   freq_hold;
	phase_t phase_cap;
	logic   phase_done;
	logic   ld_req;
	logic   access;
	logic   wr_en;
	logic   rd_en;
	logic   lock_rd;
	logic   bad;
	byte_t  rd_byte;

	assign rst     = reset_i | soft_rst_q;
	assign reset_o = rst;

	// one answer per cycle, none while the last is still up
	assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;
	assign wr_en  = access && wb_req_i.we && !bad;
	assign rd_en  = access && !wb_req_i.we && !bad;

	assign lock_rd   = (wb_req_i.adr == EXTFREQ0) || (wb_req_i.adr == EXTFREQ1) ||
		(wb_req_i.adr == EXTFREQ2);
	assign freq_hold = freq_lock || (rd_en && lock_rd);

	always_comb begin
		bad     = 1'b0;
		rd_byte = '0;
		case (wb_req_i.adr)
			GAIN:     rd_byte = gain_o;
			SETTINGS: rd_byte = {1'b0, settings_o};
			ECHO:     rd_byte = echo_q;
			STATUS: begin
				rd_byte = status_i;
				bad     = wb_req_i.we; // read only
			end
			EXTFREQ0, EXTFREQ1, EXTFREQ2, EXTFREQ3: begin
				rd_byte = freq_q[8*(wb_req_i.adr - EXTFREQ0) +: 8];
				bad     = wb_req_i.we;
			end
			PHASE_LO: rd_byte = phase_cap[7:0];
			PHASE_HI: rd_byte = {6'd0, phase_done, phase_cap[8]};
			SAMPLES0, SAMPLES1, SAMPLES2, SAMPLES3:
				rd_byte = samples_q[8*(wb_req_i.adr - SAMPLES0) +: 8];
			OFFSET0, OFFSET1, OFFSET2, OFFSET3:
				rd_byte = offset_q[8*(wb_req_i.adr - OFFSET0) +: 8];
			default: bad = 1'b1; // adcdata included, it never reaches the bus
		endcase
	end

	always_ff @(posedge ftdi_clk or posedge rst) begin
		if (rst) begin
			ack_q      <= 1'b0;
			err_q      <= 1'b0;
			gain_o     <= '0;
			settings_o <= '0;
			echo_q     <= '0;
			offset_q   <= '0;
			samples_q  <= maxsamples_i; // full depth after reset
			freq_lock  <= 1'b0;
			ld_req     <= 1'b0;
			phase_ld_o <= 1'b0;
		end else begin
			ack_q      <= access && !bad;
			err_q      <= access && bad;
			ld_req     <= 1'b0;
			phase_ld_o <= ld_req; // one cycle behind the ack
			if (rd_en) begin
				freq_lock <= lock_rd;
			end
			if (wr_en) begin
				case (wb_req_i.adr)
					GAIN:     gain_o <= wb_req_i.dat;
					SETTINGS: settings_o <= settings_t'(wb_req_i.dat[6:0]);
					ECHO:     echo_q <= wb_req_i.dat;
					PHASE_HI: ld_req <= wb_req_i.dat[1];
					SAMPLES0, SAMPLES1, SAMPLES2, SAMPLES3:
						samples_q[8*(wb_req_i.adr - SAMPLES0) +: 8] <= wb_req_i.dat;
					OFFSET0, OFFSET1, OFFSET2, OFFSET3:
						offset_q[8*(wb_req_i.adr - OFFSET0) +: 8] <= wb_req_i.dat;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge ftdi_clk) begin
		if (rd_en) begin
			dat_q <= rd_byte;
		end
		if (wr_en && (wb_req_i.adr == PHASE_LO)) begin
			phase_o[7:0] <= wb_req_i.dat;
		end
		if (wr_en && (wb_req_i.adr == PHASE_HI)) begin
			phase_o[8] <= wb_req_i.dat[0];
		end
		if (!freq_hold) begin
			freq_q <= extclk_frequency_i; // snapshot frozen during a 4 byte read
		end
	end

	// phase shifter result, dropped again by the next load
	always_ff @(posedge ftdi_clk or posedge rst) begin
		if (rst) begin
			phase_cap  <= '0;
			phase_done <= 1'b0;
		end else if (phase_ld_o) begin
			phase_cap  <= '0;
			phase_done <= 1'b0;
		end else if (phase_done_i) begin
			phase_cap  <= phase_i;
			phase_done <= 1'b1;
		end
	end

	// soft reset bit comes back one cycle later and clears itself
	always_ff @(posedge ftdi_clk or posedge reset_i) begin
		if (reset_i) begin
			soft_rst_q <= 1'b0;
		end else begin
			soft_rst_q <= settings_o.soft_reset;
		end
	end

	assign wb_rsp_o     = '{ack: ack_q, err: err_q, dat: dat_q};
	assign maxsamples_o = samples_q;
	assign trig_o       = '{arm: settings_o.arm,
		mode: settings_o.trig_mode,
		wait_inactive: settings_o.trig_wait,
		offset: offset_q};

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o; // 8 ns period
	end

	// three rising edges in reset, released on a falling edge
	initial begin
		reset_o = 1'b1;
		repeat (3) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

// ==== tb_usb_interface.sv ====
`timescale 1ns/100ps

module tb_usb_interface;
	import usb_pkg::*;

	localparam int STRM_N = 12;

	typedef enum {OP_WR, OP_RD, OP_RD_NONE} tb_op_e;

	typedef struct {
		tb_op_e    op;
		reg_addr_e addr;
		byte_t     data;
		byte_t     exp;
	} entry_t;

	logic       ftdi_clk;
	logic       reset;
	logic       rxf = 1'b0;
	logic       txe = 1'b1;
	byte_t      din = '0;
	host_rx_t   rx_bus;
	host_tx_t   tx_bus;
	byte_t      status_i = 8'h3C;
	word_t      extclk_frequency_i = 32'hA1B2_C3D4;
	word_t      maxsamples_i = 32'h0001_F400;
	phase_t     phase_i = '0;
	logic       phase_done_i = 1'b0;
	logic       fifo_empty_i = 1'b1;
	byte_t      fifo_data_i = '0;
	logic       fifo_rd_en_o;
	byte_t      gain_o;
	logic       hilow_o;
	trig_ctrl_t trig_o;
	logic       adc_clk_src_o;
	word_t      maxsamples_o;
	phase_t     phase_o;
	logic       phase_ld_o;
	logic       reset_o;

	integer     seed = 32'h265f_d4dd;
	logic       txe_rand = 1'b0;
	byte_t      rx_bytes[$];       // every byte written by the DUT
	entry_t     tbl[$];
	byte_t      stream_data[STRM_N];
	int         stream_len = 0;
	int         rd_idx = 0;
	logic       fifo_rd_seen = 1'b0;
	int         ld_cnt = 0;
	int         rst_cnt = 0;
	int         cycles = 0;
	int         timeout_limit = 0;

	assign rx_bus = '{rxf: rxf, txe: txe, din: din};

	tb_clock_gen u_clk (.clk_o(ftdi_clk), .reset_o(reset));

	usb_interface dut0 (
		.ftdi_clk(ftdi_clk), .reset(reset), .rx_i(rx_bus), .tx_o(tx_bus),
		.status_i(status_i), .extclk_frequency_i(extclk_frequency_i),
		.maxsamples_i(maxsamples_i), .phase_i(phase_i), .phase_done_i(phase_done_i),
		.fifo_empty_i(fifo_empty_i), .fifo_data_i(fifo_data_i),
		.fifo_rd_en_o(fifo_rd_en_o), .gain_o(gain_o), .hilow_o(hilow_o),
		.trig_o(trig_o), .adc_clk_src_o(adc_clk_src_o), .maxsamples_o(maxsamples_o),
		.phase_o(phase_o), .phase_ld_o(phase_ld_o), .reset_o(reset_o)
	);

	task automatic fail_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped on first error");
	endtask

	task automatic check_byte(input string name, input byte_t act, input byte_t exp);
		if (act !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, act, exp);
			fail_run();
		end
	endtask

	task automatic check_word(input string name, input word_t act, input word_t exp);
		if (act !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
			fail_run();
		end
	endtask

	task automatic check_phase(input string name, input phase_t act, input phase_t exp);
		if (act !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
			fail_run();
		end
	endtask

	task automatic check_trig(input string name, input trig_ctrl_t act,
		input trig_ctrl_t exp);
		if (act !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
			fail_run();
		end
	endtask

	// host side byte transfer from a falling edge up to the edge that shows rd
	task automatic send_byte(input byte_t b);
		din = b;
		rxf = 1'b1;
		do @(negedge ftdi_clk); while (!tx_bus.rd);
		rxf = 1'b0; // din stays for the sample after rd
	endtask

	task automatic write_reg(input reg_addr_e addr, input byte_t data);
		@(negedge ftdi_clk);
		send_byte({2'b11, addr});
		@(negedge ftdi_clk); // command byte sampled on this edge
		send_byte(data);
		repeat (4) @(negedge ftdi_clk);
	endtask

	task automatic read_reg(input reg_addr_e addr, output byte_t got, output logic seen);
		int base;
		@(negedge ftdi_clk);
		base = rx_bytes.size();
		send_byte({2'b10, addr});
		repeat (6) @(negedge ftdi_clk);
		seen = rx_bytes.size() > base;
		got  = seen ? rx_bytes[base] : 8'h00;
		if (rx_bytes.size() > base + 1) begin
			$display("more than one byte came back for one register read");
			fail_run();
		end
	endtask

	task automatic read_expect(input reg_addr_e addr, input byte_t exp);
		byte_t got;
		logic  seen;
		read_reg(addr, got, seen);
		if (!seen) begin
			$display("no byte came back for a read of address %0d", addr);
			fail_run();
		end
		check_byte($sformatf("read of addr %0d", addr), got, exp);
	endtask

	task automatic apply_entry(input entry_t e);
		byte_t got;
		logic  seen;
		case (e.op)
			OP_WR: write_reg(e.addr, e.data);
			OP_RD: read_expect(e.addr, e.exp);
			default: begin
				read_reg(e.addr, got, seen);
				if (seen) begin
					$display("read of unmapped address %0d returned a byte", e.addr);
					fail_run();
				end
			end
		endcase
	endtask

	function automatic void add_entry(tb_op_e op, reg_addr_e addr, byte_t data, byte_t exp);
		entry_t e;
		e = '{op: op, addr: addr, data: data, exp: exp};
		tbl.push_back(e);
	endfunction

	// txe is random only while a dump runs
	always @(negedge ftdi_clk) begin
		txe = txe_rand ? 1'($random(seed)) : 1'b1;
	end

	// adc fifo model gives data one cycle after rd_en
	always @(negedge ftdi_clk) begin
		if (fifo_rd_seen && rd_idx < stream_len) begin
			fifo_data_i = stream_data[rd_idx];
			rd_idx = rd_idx + 1;
		end
		fifo_empty_i = (rd_idx >= stream_len);
	end

	always @(posedge ftdi_clk) begin
		if (tx_bus.wr) begin
			rx_bytes.push_back(tx_bus.dout);
		end
		if (phase_ld_o) begin
			ld_cnt = ld_cnt + 1;
		end
		if (reset_o) begin
			rst_cnt = rst_cnt + 1;
		end
		if (fifo_rd_en_o && rd_idx >= stream_len) begin
			$display("fifo_rd_en_o pulsed while the fifo model was empty");
			fail_run();
		end
		fifo_rd_seen = fifo_rd_en_o;
		cycles = cycles + 1;
		if (timeout_limit > 0 && cycles > timeout_limit) begin
			$display("timeout after %0d cycles", cycles);
			fail_run();
		end
	end

	initial begin
		byte_t      set_b;
		byte_t      got;
		logic       seen;
		word_t      held;
		word_t      rebuilt;
		trig_ctrl_t trig_exp;
		int         base;

		set_b = 8'h6E; // clk src, wait, arm, mode and hilow set
		add_entry(OP_WR, GAIN, 8'h5A, 8'h00);
		add_entry(OP_RD, GAIN, 8'h00, 8'h5A);
		add_entry(OP_WR, ECHO, 8'hA5, 8'h00);
		add_entry(OP_RD, ECHO, 8'h00, 8'hA5);
		add_entry(OP_WR, SETTINGS, set_b, 8'h00);
		add_entry(OP_RD, SETTINGS, 8'h00, set_b);
		for (int i = 0; i < 4; i++) begin
			add_entry(OP_WR, reg_addr_e'(16 + i), byte_t'(8'h11 * (i + 1)), 8'h00);
			add_entry(OP_WR, reg_addr_e'(26 + i), byte_t'(8'h78 - 8'h22 * i), 8'h00);
		end
		for (int i = 0; i < 4; i++) begin
			add_entry(OP_RD, reg_addr_e'(16 + i), 8'h00, byte_t'(8'h11 * (i + 1)));
			add_entry(OP_RD, reg_addr_e'(26 + i), 8'h00, byte_t'(8'h78 - 8'h22 * i));
		end
		add_entry(OP_RD_NONE, reg_addr_e'(6'd20), 8'h00, 8'h00);
		add_entry(OP_RD, STATUS, 8'h00, 8'h3C);
		timeout_limit = 40 * (tbl.size() + 16) + 10 * (STRM_N + 1);

		wait (!reset);
		@(negedge ftdi_clk);
		check_word("maxsamples_o after reset", maxsamples_o, maxsamples_i);

		foreach (tbl[i]) begin
			apply_entry(tbl[i]);
		end
		check_byte("gain_o", gain_o, 8'h5A);
		check_bit("hilow_o", hilow_o, set_b[1]);
		check_bit("adc_clk_src_o", adc_clk_src_o, set_b[6]);
		check_word("maxsamples_o", maxsamples_o, 32'h4433_2211);
		trig_exp.arm           = set_b[3];
		trig_exp.mode          = set_b[2];
		trig_exp.wait_inactive = set_b[5];
		trig_exp.offset        = 32'h1234_5678;
		check_trig("trig_o", trig_o, trig_exp);

		// frequency bytes stay coherent while the input moves
		held = extclk_frequency_i;
		for (int i = 0; i < 4; i++) begin
			read_reg(reg_addr_e'(5 + i), got, seen);
			if (!seen) begin
				$display("no byte came back for frequency lane %0d", i);
				fail_run();
			end
			rebuilt[8*i +: 8] = got;
			extclk_frequency_i = $random(seed);
		end
		check_word("extclk frequency read", rebuilt, held);

		base = ld_cnt;
		write_reg(PHASE_LO, 8'h5A);
		write_reg(PHASE_HI, 8'h03); // bit 8 and load
		repeat (2) @(negedge ftdi_clk);
		check_phase("phase_o", phase_o, 9'h15A);
		if (ld_cnt - base != 1) begin
			$display("phase_ld_o was high for %0d cycles instead of one", ld_cnt - base);
			fail_run();
		end
		phase_i      = 9'h0C3; // bit 8 differs from the loaded phase
		phase_done_i = 1'b1;
		@(negedge ftdi_clk);
		phase_done_i = 1'b0;
		read_expect(PHASE_LO, 8'hC3);
		read_expect(PHASE_HI, 8'h02);

		// adc dump with random txe
		for (int i = 0; i < STRM_N; i++) begin
			stream_data[i] = byte_t'($random(seed));
		end
		stream_len = STRM_N;
		@(negedge ftdi_clk);
		base     = rx_bytes.size();
		txe_rand = 1'b1;
		send_byte({2'b10, ADCDATA});
		while (rx_bytes.size() < base + STRM_N + 1) begin
			@(negedge ftdi_clk);
		end
		txe_rand = 1'b0;
		repeat (6) @(negedge ftdi_clk);
		if (rx_bytes.size() != base + STRM_N + 1) begin
			$display("adc dump sent %0d bytes instead of %0d", rx_bytes.size() - base,
				STRM_N + 1);
			fail_run();
		end
		check_byte("dump sync byte", rx_bytes[base], SYNC_BYTE);
		for (int i = 0; i < STRM_N; i++) begin
			check_byte($sformatf("dump byte %0d", i), rx_bytes[base + 1 + i],
				stream_data[i]);
		end
		read_expect(ECHO, 8'hA5);

		// soft reset through settings bit 0
		base = rst_cnt;
		write_reg(SETTINGS, 8'h01);
		repeat (2) @(negedge ftdi_clk);
		if (rst_cnt == base) begin
			$display("reset_o never went high after the soft reset write");
			fail_run();
		end
		read_expect(SETTINGS, 8'h00);
		check_word("maxsamples_o after soft reset", maxsamples_o, maxsamples_i);
		check_byte("gain_o after soft reset", gain_o, 8'h00);

		if (tx_bus.isout === 1'b0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("isout still high with the port idle");
			fail_run();
		end
	end

endmodule

// ==== usb_interface.sv ====
`timescale 1ns/100ps

module usb_interface (
	input  logic                ftdi_clk,
	input  logic                reset,
	input  usb_pkg::host_rx_t   rx_i,
	output usb_pkg::host_tx_t   tx_o,
	input  usb_pkg::byte_t      status_i,
	input  usb_pkg::word_t      extclk_frequency_i,
	input  usb_pkg::word_t      maxsamples_i,
	input  usb_pkg::phase_t     phase_i,
	input  logic                phase_done_i,
	input  logic                fifo_empty_i,
	input  usb_pkg::byte_t      fifo_data_i,
	output logic                fifo_rd_en_o,
	output usb_pkg::byte_t      gain_o,
	output logic                hilow_o,
	output usb_pkg::trig_ctrl_t trig_o,
	output logic                adc_clk_src_o,
	output usb_pkg::word_t      maxsamples_o,
	output usb_pkg::phase_t     phase_o,
	output logic                phase_ld_o,
	output logic                reset_o
);
	import usb_pkg::*;

	wb_req_t   wb_req;
	wb_rsp_t   wb_rsp;
	strm_t     strm;
	settings_t settings;
	logic      strm_start;
	logic      strm_take;

	assign hilow_o       = settings.hilow;
	assign adc_clk_src_o = settings.adc_clk_src;

	// decode, runs on the combined reset
	host_port_fsm u_fsm (
		.ftdi_clk     (ftdi_clk),
		.reset        (reset_o),
		.rx_i         (rx_i),
		.tx_o         (tx_o),
		.wb_req_o     (wb_req),
		.wb_rsp_i     (wb_rsp),
		.strm_start_o (strm_start),
		.strm_take_o  (strm_take),
		.strm_i       (strm)
	);

	reg_bank u_regs (
		.ftdi_clk           (ftdi_clk),
		.reset_i            (reset), // source of reset_o
		.wb_req_i           (wb_req),
		.wb_rsp_o           (wb_rsp),
		.status_i           (status_i),
		.extclk_frequency_i (extclk_frequency_i),
		.maxsamples_i       (maxsamples_i),
		.phase_i            (phase_i),
		.phase_done_i       (phase_done_i),
		.gain_o             (gain_o),
		.settings_o         (settings),
		.trig_o             (trig_o),
		.maxsamples_o       (maxsamples_o),
		.phase_o            (phase_o),
		.phase_ld_o         (phase_ld_o),
		.reset_o            (reset_o)
	);

	adc_stream u_stream (
		.ftdi_clk     (ftdi_clk),
		.reset        (reset_o),
		.start_i      (strm_start),
		.take_i       (strm_take),
		.strm_o       (strm),
		.fifo_empty_i (fifo_empty_i),
		.fifo_data_i  (fifo_data_i),
		.fifo_rd_en_o (fifo_rd_en_o)
	);

endmodule

// ==== usb_interface_properties.sv ====
`timescale 1ns/100ps

module usb_interface_properties (
	input logic              ftdi_clk,
	input logic              reset,
	input usb_pkg::host_rx_t rx_i,
	input usb_pkg::host_tx_t tx_i,
	input logic              phase_ld_i,
	input logic              fifo_rd_en_i,
	input logic              fifo_empty_i
);

	a_rd_wr_excl: assert property (@(posedge ftdi_clk) disable iff (reset)
		!(tx_i.rd && tx_i.wr))
		else $error("rd and wr high in the same cycle");

	// chip back-pressure
	a_wr_txe: assert property (@(posedge ftdi_clk) disable iff (reset)
		tx_i.wr |-> (rx_i.txe && tx_i.isout))
		else $error("wr without txe or without isout");

	a_ld_pulse: assert property (@(posedge ftdi_clk) disable iff (reset)
		phase_ld_i |=> !phase_ld_i)
		else $error("phase_ld_o high for two cycles");

	a_fifo_rd: assert property (@(posedge ftdi_clk) disable iff (reset)
		!(fifo_rd_en_i && fifo_empty_i))
		else $error("fifo read while empty");

endmodule

bind usb_interface usb_interface_properties u_props (
	.ftdi_clk     (ftdi_clk),
	.reset        (reset),
	.rx_i         (rx_i),
	.tx_i         (tx_o),
	.phase_ld_i   (phase_ld_o),
	.fifo_rd_en_i (fifo_rd_en_o),
	.fifo_empty_i (fifo_empty_i)
);

// ==== usb_pkg.sv ====
package usb_pkg;

	localparam int ADDR_W = 6;

	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t;
	typedef logic [8:0]  phase_t;

	localparam byte_t SYNC_BYTE = 8'hAC; // leads every adc dump

	// host register map, low six bits of a command byte
	typedef enum logic [ADDR_W-1:0] {
		GAIN     = 6'd0,
		SETTINGS = 6'd1,
		STATUS   = 6'd2,
		ADCDATA  = 6'd3,
		ECHO     = 6'd4,
		EXTFREQ0 = 6'd5,
		EXTFREQ1 = 6'd6,
		EXTFREQ2 = 6'd7,
		EXTFREQ3 = 6'd8,
		PHASE_LO = 6'd9,
		PHASE_HI = 6'd10,
		SAMPLES0 = 6'd16,
		SAMPLES1 = 6'd17,
		SAMPLES2 = 6'd18,
		SAMPLES3 = 6'd19,
		OFFSET0  = 6'd26,
		OFFSET1  = 6'd27,
		OFFSET2  = 6'd28,
		OFFSET3  = 6'd29
	} reg_addr_e;

	// bits 7..6 of the command byte, 2'b01 counts as no command
	typedef enum logic [1:0] {
		CMD_NONE  = 2'b00,
		CMD_READ  = 2'b10,
		CMD_WRITE = 2'b11
	} cmd_op_e;

	typedef enum logic [2:0] {
		HS_IDLE,
		HS_ADDR,
		HS_WR_WAIT,
		HS_WR_DATA,
		HS_RD_REG,
		HS_RD_SEND,
		HS_STREAM
	} host_state_e;

	typedef enum logic [2:0] {
		SS_IDLE,
		SS_SYNC,
		SS_FETCH,
		SS_HOLD,
		SS_DONE
	} strm_state_e;

	typedef struct packed {
		logic  rxf; // byte waiting in the chip
		logic  txe; // room for a byte
		byte_t din;
	} host_rx_t;

	typedef struct packed {
		logic  rd;
		logic  wr;
		logic  isout;
		byte_t dout;
	} host_tx_t;

	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		reg_addr_e adr;
		byte_t     dat;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		logic  err;
		byte_t dat;
	} wb_rsp_t;

	// settings byte, bit 0 at the bottom
	typedef struct packed {
		logic adc_clk_src;
		logic trig_wait;
		logic pll_reset;
		logic arm;
		logic trig_mode;
		logic hilow;
		logic soft_reset;
	} settings_t;

	typedef struct packed {
		logic  arm;
		logic  mode;
		logic  wait_inactive; // hold off until trigger line drops
		word_t offset;
	} trig_ctrl_t;

	typedef struct packed {
		logic  valid;
		logic  done;
		byte_t data;
	} strm_t;

endpackage
